// File: source/phold_pkg.sv
/*
 * Shared constants and types for the PHOLD accelerator personality.
 * Every RTL file refers to these by scoped name (phold_pkg::name).
 */

package phold_pkg;

   // -------------------------------------------------------------------
   // Widths and counts
   // -------------------------------------------------------------------
   localparam int data_w     = 64;
   localparam int aeg_count  = 16;
   localparam int aeg_idx_w  = 18;
   localparam int ts_w       = 16;
   localparam int num_slots  = 8;
   localparam int slot_idx_w = 3;

   // AEG register map
   localparam int aeg_sim_end      = 0;  // Low 16 bits = end time
   localparam int aeg_num_init     = 1;  // Low 4 bits = initial events
   localparam int aeg_gvt          = 2;
   localparam int aeg_total_cycles = 3;
   localparam int aeg_total_events = 4;

   // Scheduling LFSR, Galois form shifting right
   localparam logic [ts_w-1:0] lfsr_seed = 16'hace1;
   localparam logic [ts_w-1:0] lfsr_taps = 16'hb400;

   // -------------------------------------------------------------------
   // Control
   // -------------------------------------------------------------------
   typedef enum logic [1:0] {
      st_idle     = 2'd0,
      st_running  = 2'd1,
      st_finished = 2'd2
   } pers_state_t;

   localparam logic [4:0]  inst_start = 5'd0;
   localparam logic [15:0] csr_status = 16'h0000;
   localparam logic [15:0] csr_gvt    = 16'h0001;

   // Bit positions in disp_exception
   localparam int exc_unimpl  = 0;
   localparam int exc_aeg_idx = 1;

endpackage

// File: source/pers_if.sv
/*
 * Bundles passed between the personality blocks.
 * phold_cfg_if carries the run setup and start strobe, phold_report_if
 * carries the engine results back.
 */

`timescale 1ns/1ps

interface phold_cfg_if;
   // Single-cycle launch strobe
   logic                        start;
   logic [phold_pkg::ts_w-1:0]  sim_end;
   logic [3:0]                  num_init;
   // High while the FSM is not idle
   logic                        busy;

   modport regs   (output start, output sim_end, output num_init, input busy);
   modport ctrl   (input start, output busy);
   modport engine (input start, input sim_end, input num_init);
endinterface

interface phold_report_if;
   // Single-cycle end-of-run strobe, values held afterwards
   logic                          done;
   logic [phold_pkg::ts_w-1:0]    gvt;
   logic [phold_pkg::data_w-1:0]  total_cycles;
   logic [phold_pkg::data_w-1:0]  total_events;

   modport engine (output done, output gvt, output total_cycles, output total_events);
   modport regs   (input done, input gvt, input total_cycles, input total_events);
   modport ctrl   (input done);
endinterface

// File: source/aeg_regfile.sv
/*
 * AEG bank behind the dispatch port.
 * Serves host reads and writes, turns the start instruction into the
 * engine start strobe and captures the run results on done.
 */

`timescale 1ns/1ps

module aeg_regfile (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              disp_inst_vld,
   input  logic [4:0]                        disp_inst,
   input  logic [phold_pkg::aeg_idx_w-1:0]   disp_aeg_idx,
   input  logic                              disp_aeg_rd,
   input  logic                              disp_aeg_wr,
   input  logic [phold_pkg::data_w-1:0]      disp_aeg_wr_data,
   output logic                              disp_rtn_data_vld,
   output logic [phold_pkg::data_w-1:0]      disp_rtn_data,
   output logic [15:0]                       disp_exception,
   phold_cfg_if.regs                         cfg,
   phold_report_if.regs                      rpt
);

   logic [phold_pkg::data_w-1:0] aeg [phold_pkg::aeg_count];
   logic [phold_pkg::data_w-1:0] rd_word;
   logic                         idx_ok;

   assign idx_ok = disp_aeg_idx < phold_pkg::aeg_count;

   // Read mux, falls to zero on out-of-range index
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < phold_pkg::aeg_count; i++) begin
         if (disp_aeg_idx == i)
            rd_word = aeg[i];
      end
   end

   // -------------------------------------------------------------------
   // Register bank
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < phold_pkg::aeg_count; i++)
            aeg[i] <= '0;
      end else begin
         for (int i = 0; i < phold_pkg::aeg_count; i++) begin
            if (disp_aeg_wr && disp_aeg_idx == i)
               aeg[i] <= disp_aeg_wr_data;
         end
         // Engine results override a host write in the same cycle
         if (rpt.done) begin
            aeg[phold_pkg::aeg_gvt] <=
               {{(phold_pkg::data_w - phold_pkg::ts_w){1'b0}}, rpt.gvt};
            aeg[phold_pkg::aeg_total_cycles] <= rpt.total_cycles;
            aeg[phold_pkg::aeg_total_events] <= rpt.total_events;
         end
      end
   end

   // Run setup straight from the bank
   assign cfg.sim_end  = aeg[phold_pkg::aeg_sim_end][phold_pkg::ts_w-1:0];
   assign cfg.num_init = aeg[phold_pkg::aeg_num_init][3:0];

   // -------------------------------------------------------------------
   // Dispatch return, start decode, exceptions
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         disp_rtn_data_vld <= 1'b0;
         disp_exception    <= '0;
         cfg.start         <= 1'b0;
      end else begin
         disp_rtn_data_vld <= disp_aeg_rd;
         disp_exception    <= '0;
         disp_exception[phold_pkg::exc_unimpl] <=
            disp_inst_vld && disp_inst != phold_pkg::inst_start;
         disp_exception[phold_pkg::exc_aeg_idx] <=
            (disp_aeg_rd || disp_aeg_wr) && !idx_ok;
         // Drop starts while a run is pending or active
         cfg.start <= disp_inst_vld && disp_inst == phold_pkg::inst_start &&
                      !cfg.busy && !cfg.start;
      end
   end

   always_ff @(posedge clk) begin
      disp_rtn_data <= rd_word;
   end

endmodule

// File: source/pers_ctrl.sv
/*
 * Personality control FSM.
 * Tracks idle, running and finished, and tells the host when the
 * personality is idle or must not be sent new work.
 */

`timescale 1ns/1ps

module pers_ctrl (
   input  logic                   clk,
   input  logic                   rst_n,
   phold_cfg_if.ctrl              cfg,
   phold_report_if.ctrl           rpt,
   output phold_pkg::pers_state_t state,
   output logic                   disp_idle,
   output logic                   disp_stall
);

   phold_pkg::pers_state_t state_nxt;

   // -------------------------------------------------------------------
   // Next state
   // -------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         phold_pkg::st_idle: begin
            if (cfg.start)
               state_nxt = phold_pkg::st_running;
         end
         phold_pkg::st_running: begin
            // Leave once the engine reports the end of the run
            if (rpt.done)
               state_nxt = phold_pkg::st_finished;
         end
         phold_pkg::st_finished: begin
            state_nxt = phold_pkg::st_idle;
         end
         default: begin
            state_nxt = phold_pkg::st_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         state <= phold_pkg::st_idle;
      else
         state <= state_nxt;
   end

   // Host status
   assign cfg.busy   = state != phold_pkg::st_idle;
   assign disp_idle  = state == phold_pkg::st_idle && !cfg.start;
   assign disp_stall = !disp_idle;

endmodule

// File: source/phold_engine.sv
/*
 * PHOLD event engine with eight on-chip event slots.
 * Each cycle pops the earliest event and reschedules it at a random
 * later time until the earliest timestamp reaches the end time.
 */

`timescale 1ns/1ps

module phold_engine (
   input  logic            clk,
   input  logic            rst_n,
   phold_cfg_if.engine     cfg,
   phold_report_if.engine  rpt
);

   logic [phold_pkg::ts_w-1:0]       slot_ts [phold_pkg::num_slots];
   logic [phold_pkg::num_slots-1:0]  slot_occ;
   logic [phold_pkg::ts_w-1:0]       lfsr;
   logic                             active;

   logic [3:0]                       n_init;
   logic [phold_pkg::ts_w-1:0]       min_ts;
   logic [phold_pkg::slot_idx_w-1:0] min_idx;
   logic                             min_found;
   logic [phold_pkg::ts_w-1:0]       next_ts;
   logic [phold_pkg::ts_w-1:0]       lfsr_nxt;

   // Initial event count clamped to 1..8
   always_comb begin
      n_init = cfg.num_init;
      if (cfg.num_init == 4'd0)
         n_init = 4'd1;
      else if (cfg.num_init > phold_pkg::num_slots)
         n_init = 4'(phold_pkg::num_slots);
   end

   // -------------------------------------------------------------------
   // Minimum search, strict compare keeps the lowest slot on ties
   // -------------------------------------------------------------------
   always_comb begin
      min_ts    = '0;
      min_idx   = '0;
      min_found = 1'b0;
      for (int i = 0; i < phold_pkg::num_slots; i++) begin
         if (slot_occ[i] && (!min_found || slot_ts[i] < min_ts)) begin
            min_ts    = slot_ts[i];
            min_idx   = i[phold_pkg::slot_idx_w-1:0];
            min_found = 1'b1;
         end
      end
   end

   // Follow-on event 1 to 16 ticks later
   assign next_ts = min_ts + {{(phold_pkg::ts_w - 4){1'b0}}, lfsr[3:0]} + 1'b1;

   // Galois step
   assign lfsr_nxt = lfsr[0] ? ((lfsr >> 1) ^ phold_pkg::lfsr_taps) : (lfsr >> 1);

   // -------------------------------------------------------------------
   // Run control and counters
   // -------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_occ         <= '0;
         lfsr             <= phold_pkg::lfsr_seed;
         active           <= 1'b0;
         rpt.done         <= 1'b0;
         rpt.gvt          <= '0;
         rpt.total_cycles <= '0;
         rpt.total_events <= '0;
      end else begin
         rpt.done <= 1'b0;
         if (cfg.start) begin
            for (int i = 0; i < phold_pkg::num_slots; i++)
               slot_occ[i] <= i < n_init;
            lfsr             <= phold_pkg::lfsr_seed;
            active           <= 1'b1;
            rpt.total_cycles <= '0;
            rpt.total_events <= '0;
         end else if (active) begin
            rpt.total_cycles <= rpt.total_cycles + 1'b1;
            lfsr             <= lfsr_nxt;
            if (min_ts >= cfg.sim_end) begin
               // End of run, earliest pending time is the GVT
               rpt.done <= 1'b1;
               rpt.gvt  <= min_ts;
               active   <= 1'b0;
            end else begin
               rpt.total_events <= rpt.total_events + 1'b1;
            end
         end
      end
   end

   // Slot timestamps
   always_ff @(posedge clk) begin
      if (cfg.start) begin
         for (int i = 0; i < phold_pkg::num_slots; i++)
            slot_ts[i] <= i[phold_pkg::ts_w-1:0];
      end else if (active && min_ts < cfg.sim_end) begin
         slot_ts[min_idx] <= next_ts;
      end
   end

endmodule

// File: source/csr_responder.sv
/*
 * Management port read responder.
 * Returns the FSM state or the last GVT one cycle after a read strobe.
 */

`timescale 1ns/1ps

module csr_responder (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          csr_rd_vld,
   input  logic [15:0]                   csr_address,
   input  phold_pkg::pers_state_t        state,
   input  logic [phold_pkg::ts_w-1:0]    gvt,
   output logic                          csr_rd_ack,
   output logic [phold_pkg::data_w-1:0]  csr_rd_data
);

   logic [phold_pkg::data_w-1:0] rd_word;

   // Address decode, unknown addresses read zero
   always_comb begin
      case (csr_address)
         phold_pkg::csr_status:
            rd_word = {{(phold_pkg::data_w - 2){1'b0}}, state};
         phold_pkg::csr_gvt:
            rd_word = {{(phold_pkg::data_w - phold_pkg::ts_w){1'b0}}, gvt};
         default:
            rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         csr_rd_ack <= 1'b0;
      else
         csr_rd_ack <= csr_rd_vld;
   end

   always_ff @(posedge clk) begin
      csr_rd_data <= rd_word;
   end

endmodule

// File: source/phold_pers.sv
/*
 * Top level of the PHOLD personality.
 * Connects the register file, control FSM, event engine and CSR
 * responder to the dispatch and management ports.
 */

`timescale 1ns/1ps

module phold_pers (
   input  logic         clk,
   input  logic         rst_n,
   // Dispatch
   input  logic         disp_inst_vld,
   input  logic [4:0]   disp_inst,
   input  logic [17:0]  disp_aeg_idx,
   input  logic         disp_aeg_rd,
   input  logic         disp_aeg_wr,
   input  logic [63:0]  disp_aeg_wr_data,
   output logic [15:0]  disp_exception,
   output logic         disp_idle,
   output logic         disp_rtn_data_vld,
   output logic [63:0]  disp_rtn_data,
   output logic         disp_stall,
   // Management, writes have no target here
   input  logic         csr_wr_vld,
   input  logic         csr_rd_vld,
   input  logic [15:0]  csr_address,
   input  logic [63:0]  csr_wr_data,
   output logic         csr_rd_ack,
   output logic [63:0]  csr_rd_data
);

   phold_pkg::pers_state_t state;

   phold_cfg_if    cfg_if ();
   phold_report_if rpt_if ();

   // -------------------------------------------------------------------
   // Input side
   // -------------------------------------------------------------------
   aeg_regfile aeg_regfile_i (
      .clk               (clk),
      .rst_n             (rst_n),
      .disp_inst_vld     (disp_inst_vld),
      .disp_inst         (disp_inst),
      .disp_aeg_idx      (disp_aeg_idx),
      .disp_aeg_rd       (disp_aeg_rd),
      .disp_aeg_wr       (disp_aeg_wr),
      .disp_aeg_wr_data  (disp_aeg_wr_data),
      .disp_rtn_data_vld (disp_rtn_data_vld),
      .disp_rtn_data     (disp_rtn_data),
      .disp_exception    (disp_exception),
      .cfg               (cfg_if.regs),
      .rpt               (rpt_if.regs)
   );

   // -------------------------------------------------------------------
   // Processing
   // -------------------------------------------------------------------
   pers_ctrl pers_ctrl_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg        (cfg_if.ctrl),
      .rpt        (rpt_if.ctrl),
      .state      (state),
      .disp_idle  (disp_idle),
      .disp_stall (disp_stall)
   );

   phold_engine phold_engine_i (
      .clk   (clk),
      .rst_n (rst_n),
      .cfg   (cfg_if.engine),
      .rpt   (rpt_if.engine)
   );

   // Output side
   csr_responder csr_responder_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_rd_vld  (csr_rd_vld),
      .csr_address (csr_address),
      .state       (state),
      .gvt         (rpt_if.gvt),
      .csr_rd_ack  (csr_rd_ack),
      .csr_rd_data (csr_rd_data)
   );

endmodule

// File: testbench/tb_phold_model.svh
/*
 * Reference model of the PHOLD event engine for the testbench.
 * Replays slot loading, minimum search and LFSR scheduling to predict
 * the GVT and the processed event count of one run.
 */

`ifndef TB_PHOLD_MODEL_SVH
`define TB_PHOLD_MODEL_SVH

// Initial event count as seen by the engine, 1 to 8
function automatic int clamp_init(input logic [3:0] num_init);
   if (num_init == 4'd0)
      return 1;
   if (num_init > 4'd8)
      return 8;
   return int'(num_init);
endfunction

// One Galois step, shift right then fold in the taps
function automatic logic [15:0] lfsr_step(input logic [15:0] value);
   logic [15:0] shifted;
   shifted = value >> 1;
   if (value[0])
      shifted = shifted ^ phold_pkg::lfsr_taps;
   return shifted;
endfunction

// Full run from start to the end condition
task automatic model_run(input logic [15:0] sim_end, input logic [3:0] num_init,
                         output logic [15:0] gvt, output longint events);
   logic [15:0] ts [8];
   bit          occ [8];
   logic [15:0] lfsr;
   logic [15:0] best;
   int          best_idx;
   int          n;
   bit          ended;
   n = clamp_init(num_init);
   for (int i = 0; i < 8; i++) begin
      ts[i] = 16'(i);
      occ[i] = i < n;
   end
   lfsr = phold_pkg::lfsr_seed;
   events = 0;
   ended = 1'b0;
   gvt = '0;
   while (!ended && events < 100000) begin
      best_idx = -1;
      best = '0;
      // Earliest event, first slot wins a tie
      for (int i = 0; i < 8; i++) begin
         if (occ[i] && (best_idx < 0 || ts[i] < best)) begin
            best = ts[i];
            best_idx = i;
         end
      end
      if (best >= sim_end) begin
         gvt = best;
         ended = 1'b1;
      end else begin
         ts[best_idx] = best + 16'(lfsr[3:0]) + 16'd1;
         events++;
      end
      lfsr = lfsr_step(lfsr);
   end
endtask

`endif

// File: testbench/tb_phold_pers.sv
/*
 * Testbench for the PHOLD personality top level.
 * Runs reset, AEG access, exception, engine run and CSR tests with
 * seeded random stimulus and compares against the reference model.
 */

`timescale 1ns/1ps

module tb_phold_pers;

   logic        clk;
   logic        rst_n;
   logic        disp_inst_vld;
   logic [4:0]  disp_inst;
   logic [17:0] disp_aeg_idx;
   logic        disp_aeg_rd;
   logic        disp_aeg_wr;
   logic [63:0] disp_aeg_wr_data;
   logic [15:0] disp_exception;
   logic        disp_idle;
   logic        disp_rtn_data_vld;
   logic [63:0] disp_rtn_data;
   logic        disp_stall;
   logic        csr_wr_vld;
   logic        csr_rd_vld;
   logic [15:0] csr_address;
   logic [63:0] csr_wr_data;
   logic        csr_rd_ack;
   logic [63:0] csr_rd_data;

   int errors = 0;
   int test_err_base = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   `include "tb_phold_model.svh"

   phold_pers phold_pers_i (.*);

   // 4 ns period
   always #2 clk = ~clk;

   // -------------------------------------------------------------------
   // Checks and bus tasks entered on a falling edge
   // -------------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else begin
         $display("** Error %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic require(input string name, input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("%s: %s", name, what);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_err_base) begin
         $display("Test %s: passed", name);
         tests_passed++;
      end else begin
         $display("Test %s: %0d check(s) wrong", name, errors - test_err_base);
         tests_failed++;
      end
      test_err_base = errors;
   endtask

   task automatic write_aeg(input logic [17:0] idx, input logic [63:0] data);
      disp_aeg_idx = idx;
      disp_aeg_wr_data = data;
      disp_aeg_wr = 1'b1;
      @(negedge clk);
      disp_aeg_wr = 1'b0;
   endtask

   // Return data and exception show up together
   task automatic read_aeg(input logic [17:0] idx, output logic [63:0] data,
                           output logic [15:0] exc);
      int cnt;
      disp_aeg_idx = idx;
      disp_aeg_rd = 1'b1;
      @(negedge clk);
      disp_aeg_rd = 1'b0;
      cnt = 0;
      while (!disp_rtn_data_vld && cnt < 8) begin
         @(negedge clk);
         cnt++;
      end
      require("read_aeg", disp_rtn_data_vld, "no AEG read return within 8 cycles");
      require("read_aeg", cnt == 0, "AEG read return came later than one cycle");
      data = disp_rtn_data;
      exc = disp_exception;
      @(negedge clk);
   endtask

   task automatic read_csr(input logic [15:0] addr, output logic [63:0] data);
      int cnt;
      csr_address = addr;
      csr_rd_vld = 1'b1;
      @(negedge clk);
      csr_rd_vld = 1'b0;
      cnt = 0;
      while (!csr_rd_ack && cnt < 8) begin
         @(negedge clk);
         cnt++;
      end
      require("read_csr", csr_rd_ack, "no CSR acknowledge within 8 cycles");
      require("read_csr", cnt == 0, "CSR acknowledge came later than one cycle");
      data = csr_rd_data;
      @(negedge clk);
   endtask

   task automatic issue_inst(input logic [4:0] code);
      disp_inst = code;
      disp_inst_vld = 1'b1;
      @(negedge clk);
      disp_inst_vld = 1'b0;
   endtask

   // Setup AEGs carry random upper bits
   task automatic start_run(input logic [15:0] sim_end, input logic [3:0] num_init,
                            input string name);
      write_aeg(18'(phold_pkg::aeg_sim_end), {$urandom, 16'($urandom), sim_end});
      write_aeg(18'(phold_pkg::aeg_num_init), {$urandom, 28'($urandom), num_init});
      issue_inst(phold_pkg::inst_start);
      require(name, disp_stall, "disp_stall low right after start");
   endtask

   task automatic wait_idle(input string name);
      int cnt;
      cnt = 0;
      while (!disp_idle && cnt < 20000) begin
         require(name, disp_stall, "disp_stall low while the run is active");
         @(negedge clk);
         cnt++;
      end
      require(name, disp_idle, "timed out waiting for disp_idle after start");
   endtask

   // -------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------
   initial begin
      logic [63:0] rd_data;
      logic [15:0] exc;
      logic [63:0] shadow [16];
      logic [17:0] idx;
      logic [15:0] sim_end;
      logic [3:0]  num_init;
      logic [15:0] exp_gvt;
      longint      exp_events;
      void'($urandom(32'hdbd4_04b7));
      clk = 1'b0;
      rst_n = 1'b0;
      disp_inst_vld = 1'b0;
      disp_inst = '0;
      disp_aeg_idx = '0;
      disp_aeg_rd = 1'b0;
      disp_aeg_wr = 1'b0;
      disp_aeg_wr_data = '0;
      csr_wr_vld = 1'b0;
      csr_rd_vld = 1'b0;
      csr_address = '0;
      csr_wr_data = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      // Reset values and a few random AEGs
      check_value("reset_state idle", 64'(1), 64'(disp_idle));
      check_value("reset_state stall", 64'(0), 64'(disp_stall));
      check_value("reset_state exception", 64'(0), 64'(disp_exception));
      check_value("reset_state rtn_vld", 64'(0), 64'(disp_rtn_data_vld));
      check_value("reset_state csr_ack", 64'(0), 64'(csr_rd_ack));
      repeat (4) begin
         read_aeg(18'($urandom_range(15, 0)), rd_data, exc);
         check_value("reset_state aeg", 64'(0), rd_data);
      end
      finish_test("reset_state");

      // Fill the whole bank and read it back
      for (int i = 0; i < 16; i++) begin
         shadow[i] = {$urandom, $urandom};
         write_aeg(18'(i), shadow[i]);
      end
      for (int i = 0; i < 16; i++) begin
         read_aeg(18'(i), rd_data, exc);
         check_value("aeg_access data", shadow[i], rd_data);
         check_value("aeg_access exception", 64'(0), 64'(exc));
      end
      repeat (3) begin
         idx = 18'($urandom_range(18'h3ffff, 16));
         read_aeg(idx, rd_data, exc);
         check_value("aeg_access out_of_range data", 64'(0), rd_data);
         check_value("aeg_access out_of_range exc", 64'(2), 64'(exc));
      end
      finish_test("aeg_access");

      // Nonzero code is not implemented
      issue_inst(5'($urandom_range(31, 1)));
      check_value("unimpl_inst exception", 64'(1), 64'(disp_exception));
      check_value("unimpl_inst idle", 64'(1), 64'(disp_idle));
      @(negedge clk);
      check_value("unimpl_inst pulse end", 64'(0), 64'(disp_exception));
      finish_test("unimpl_inst");

      // Engine runs against the model
      for (int r = 0; r < 6; r++) begin
         sim_end = 16'($urandom_range(600, 0));
         num_init = 4'($urandom_range(9, 0));
         model_run(sim_end, num_init, exp_gvt, exp_events);
         start_run(sim_end, num_init, "engine_runs");
         wait_idle("engine_runs");
         read_aeg(18'(phold_pkg::aeg_gvt), rd_data, exc);
         check_value("engine_runs gvt", 64'(exp_gvt), rd_data);
         read_aeg(18'(phold_pkg::aeg_total_cycles), rd_data, exc);
         check_value("engine_runs cycles", 64'(exp_events + 1), rd_data);
         read_aeg(18'(phold_pkg::aeg_total_events), rd_data, exc);
         check_value("engine_runs events", 64'(exp_events), rd_data);
      end
      finish_test("engine_runs");

      // Status during and after a run, GVT and an unknown address
      sim_end = 16'($urandom_range(600, 300));
      num_init = 4'($urandom_range(8, 1));
      model_run(sim_end, num_init, exp_gvt, exp_events);
      start_run(sim_end, num_init, "csr_reads");
      @(negedge clk);
      read_csr(phold_pkg::csr_status, rd_data);
      check_value("csr_reads status running", 64'(1), rd_data);
      wait_idle("csr_reads");
      read_csr(phold_pkg::csr_status, rd_data);
      check_value("csr_reads status idle", 64'(0), rd_data);
      read_csr(phold_pkg::csr_gvt, rd_data);
      check_value("csr_reads gvt", 64'(exp_gvt), rd_data);
      read_csr(16'($urandom_range(16'hffff, 2)), rd_data);
      check_value("csr_reads unknown", 64'(0), rd_data);
      finish_test("csr_reads");

      $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

// File: phold_pers.f
+incdir+testbench
source/phold_pkg.sv
source/pers_if.sv
source/aeg_regfile.sv
source/pers_ctrl.sv
source/phold_engine.sv
source/csr_responder.sv
source/phold_pers.sv
testbench/tb_phold_pers.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PHOLD personality testbench with Verilator, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_phold_pers \
   -f phold_pers.f -o sim_phold_pers > build.log 2>&1 &&
./obj_dir/sim_phold_pers > sim.log 2>&1 ||
{ cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "Simulation FAILED"; exit 1; } ||
grep -q "Done: no errors" sim.log && echo "Simulation PASSED" ||
{ echo "Simulation ended without a result"; exit 1; }
